// File: hdl/pext_params.svh
/*
 * Word geometry and clamp bounds for the packed-SIMD unit.
 * Lane logic assumes four 8-bit bytes per word; changing widths alone is not enough.
 */
`ifndef PEXT_PARAMS_SVH
`define PEXT_PARAMS_SVH

// Word geometry
`define PEXT_XLEN        32
`define PEXT_BYTE_W      8
`define PEXT_NUM_BYTES   4

// Signed clamp bounds per lane width
`define PEXT_SAT_S8_MIN  8'h80
`define PEXT_SAT_S8_MAX  8'h7f
`define PEXT_SAT_S16_MIN 16'h8000
`define PEXT_SAT_S16_MAX 16'h7fff
`define PEXT_SAT_S32_MIN 32'h8000_0000
`define PEXT_SAT_S32_MAX 32'h7fff_ffff

// Unsigned upper bound, replicated per byte for wider lanes
`define PEXT_SAT_U8_MAX  8'hff

`endif

// File: hdl/pext_op_pkg.sv
/*
 * Opcodes, lane widths and decoded control for the packed-SIMD unit.
 * Lane width encoding 2'b11 is treated like 32-bit lanes.
 */
`include "pext_params.svh"

package pext_op_pkg;

  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_KADD, OP_UKADD, OP_KSUB, OP_UKSUB,
    OP_RADD, OP_URADD, OP_RSUB, OP_URSUB,
    OP_CMPEQ, OP_SCMPLT, OP_UCMPLT,
    OP_SMIN, OP_SMAX, OP_UMIN, OP_UMAX
  } pext_op_e;

  typedef enum logic [1:0] {
    W8  = 2'd0,
    W16 = 2'd1,
    W32 = 2'd2
  } lane_width_e;

  typedef enum logic [2:0] {
    RES_WRAP, RES_SAT, RES_HALF, RES_CMP, RES_MINMAX
  } res_kind_e;

  typedef struct packed {
    lane_width_e width;
    logic        sub;
    logic        signed_op;
    res_kind_e   res_kind;
    logic        cmp_eq;
    logic        pick_max;
  } pext_ctrl_t;

  // Bytes that hold the MSB of a lane
  function automatic logic [`PEXT_NUM_BYTES-1:0] lane_top_mask(lane_width_e width);
    case (width)
      W8:      return 4'b1111;
      W16:     return 4'b1010;
      default: return 4'b1000;
    endcase
  endfunction

  // Copy each lane-top flag to every byte of its lane
  function automatic logic [`PEXT_NUM_BYTES-1:0] lane_spread(
    lane_width_e width, logic [`PEXT_NUM_BYTES-1:0] flags);
    case (width)
      W8:      return flags;
      W16:     return {{2{flags[3]}}, {2{flags[1]}}};
      default: return {4{flags[3]}};
    endcase
  endfunction

endpackage

// File: hdl/pext_data_pkg.sv
/*
 * Data types carried between the stages of the packed-SIMD unit.
 * Each byte sum keeps one extra bit for carry or sign at the byte top.
 */
`include "pext_params.svh"

package pext_data_pkg;

  // One machine word
  typedef logic [`PEXT_XLEN-1:0] xlen_t;

  // Per-byte adder output, bit 8 is carry out or the extended sign
  typedef logic [`PEXT_NUM_BYTES-1:0][`PEXT_BYTE_W:0] lane_sum_t;

  // Both source operands travel together
  typedef struct packed {
    xlen_t a;
    xlen_t b;
  } pext_operands_t;

endpackage

// File: hdl/pext_decode.sv
/*
 * Input side. Control and operands load only while valid_i is high,
 * so they hold their last value between requests.
 */
`include "pext_params.svh"

module pext_decode (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          valid_i,
  input  pext_op_pkg::pext_op_e         op_i,
  input  pext_op_pkg::lane_width_e      width_i,
  input  pext_data_pkg::pext_operands_t operands_i,
  output pext_op_pkg::pext_ctrl_t       ctrl_o,
  output pext_data_pkg::pext_operands_t operands_o,
  output logic                          valid_o
);

  import pext_op_pkg::*;
  import pext_data_pkg::*;

  pext_ctrl_t ctrl_d;

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    ctrl_d       = '0;
    ctrl_d.width = width_i;

    case (op_i)
      OP_ADD, OP_SUB:                      ctrl_d.res_kind = RES_WRAP;
      OP_KADD, OP_UKADD, OP_KSUB, OP_UKSUB: ctrl_d.res_kind = RES_SAT;
      OP_RADD, OP_URADD, OP_RSUB, OP_URSUB: ctrl_d.res_kind = RES_HALF;
      OP_CMPEQ, OP_SCMPLT, OP_UCMPLT:      ctrl_d.res_kind = RES_CMP;
      OP_SMIN, OP_SMAX, OP_UMIN, OP_UMAX:  ctrl_d.res_kind = RES_MINMAX;
      default:                             ctrl_d.res_kind = RES_WRAP;
    endcase

    // Compares and min/max work on a - b
    ctrl_d.sub = (op_i inside {OP_SUB, OP_KSUB, OP_UKSUB, OP_RSUB, OP_URSUB}) ||
                 (ctrl_d.res_kind inside {RES_CMP, RES_MINMAX});
    ctrl_d.signed_op = op_i inside {OP_KADD, OP_KSUB, OP_RADD, OP_RSUB,
                                    OP_SCMPLT, OP_SMIN, OP_SMAX};
    ctrl_d.cmp_eq   = (op_i == OP_CMPEQ);
    ctrl_d.pick_max = op_i inside {OP_SMAX, OP_UMAX};
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 1 registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      ctrl_o     <= ctrl_d;
      operands_o <= operands_i;
    end
  end

  // Every accepted request carries a defined opcode
  assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i |-> !$isunknown(op_i) && (op_i inside {[OP_ADD:OP_UMAX]}))
    else $error("undefined opcode accepted by decode");

endmodule

// File: hdl/pext_lane_adder.sv
/*
 * Byte-sliced adder shared by every operation of the unit.
 * Purely combinational; the carry chain breaks at each lane top.
 */
`include "pext_params.svh"

module pext_lane_adder (
  input  pext_op_pkg::pext_ctrl_t       ctrl_i,
  input  pext_data_pkg::pext_operands_t operands_i,
  output pext_data_pkg::lane_sum_t      sum_o
);

  import pext_op_pkg::*;
  import pext_data_pkg::*;

  localparam int NB = `PEXT_NUM_BYTES;
  localparam int BW = `PEXT_BYTE_W;

  logic [NB-1:0]         top;
  logic [NB-1:0][BW-1:0] a_byte;
  logic [NB-1:0][BW-1:0] b_byte;
  logic [NB-1:0]         ext_a;
  logic [NB-1:0]         ext_b;
  logic [NB-1:0]         cin;

  assign top = lane_top_mask(ctrl_i.width);

  for (genvar k = 0; k < NB; k++) begin : gen_byte
    // Subtraction as a + ~b + 1
    assign a_byte[k] = operands_i.a[BW*k +: BW];
    assign b_byte[k] = ctrl_i.sub ? ~operands_i.b[BW*k +: BW] : operands_i.b[BW*k +: BW];

    // Sign extension only at lane tops, zero below so bit 8 is the carry
    assign ext_a[k] = ctrl_i.signed_op & top[k] & a_byte[k][BW-1];
    assign ext_b[k] = ctrl_i.signed_op & top[k] & b_byte[k][BW-1];

    if (k == 0) begin : gen_first
      assign cin[k] = ctrl_i.sub;
    end else begin : gen_chain
      // New lane restarts with the subtract carry-in
      assign cin[k] = top[k-1] ? ctrl_i.sub : sum_o[k-1][BW];
    end

    assign sum_o[k] = {ext_a[k], a_byte[k]} + {ext_b[k], b_byte[k]} + {{BW{1'b0}}, cin[k]};
  end

endmodule

// File: hdl/pext_compare.sv
/*
 * Lane compare and min/max selection from the adder difference.
 * Results are only meaningful when the control requests a subtract.
 */
`include "pext_params.svh"

module pext_compare (
  input  pext_op_pkg::pext_ctrl_t       ctrl_i,
  input  pext_data_pkg::pext_operands_t operands_i,
  input  pext_data_pkg::lane_sum_t      sum_i,
  output pext_data_pkg::xlen_t          cmp_word_o,
  output pext_data_pkg::xlen_t          minmax_word_o
);

  import pext_op_pkg::*;
  import pext_data_pkg::*;

  localparam int NB = `PEXT_NUM_BYTES;
  localparam int BW = `PEXT_BYTE_W;

  logic [NB-1:0] byte_zero;
  logic [NB-1:0] byte_less;
  logic [NB-1:0] lane_eq;
  logic [NB-1:0] lane_less;
  logic [NB-1:0] pick;
  logic [NB-1:0] take_a;

  // Per byte zero test and less-than at the byte MSB
  always_comb begin
    logic a_top;
    logic b_top;
    for (int k = 0; k < NB; k++) begin
      a_top        = operands_i.a[BW*k+BW-1];
      b_top        = operands_i.b[BW*k+BW-1];
      byte_zero[k] = (sum_i[k][BW-1:0] == '0);
      // Differing tops decide directly, otherwise the difference sign does
      if (a_top == b_top) begin
        byte_less[k] = sum_i[k][BW-1];
      end else begin
        byte_less[k] = ctrl_i.signed_op ? a_top : b_top;
      end
    end
  end

  // Lane equal needs every byte of the lane zero
  always_comb begin
    case (ctrl_i.width)
      W8:      lane_eq = byte_zero;
      W16:     lane_eq = {{2{&byte_zero[3:2]}}, {2{&byte_zero[1:0]}}};
      default: lane_eq = {4{&byte_zero}};
    endcase
  end

  assign lane_less = lane_spread(ctrl_i.width, byte_less);
  assign pick      = ctrl_i.cmp_eq ? lane_eq : lane_less;

  // max keeps a when a >= b
  assign take_a = lane_less ^ {NB{ctrl_i.pick_max}};

  always_comb begin
    for (int k = 0; k < NB; k++) begin
      cmp_word_o[BW*k +: BW]    = {BW{pick[k]}};
      minmax_word_o[BW*k +: BW] = take_a[k] ? operands_i.a[BW*k +: BW]
                                            : operands_i.b[BW*k +: BW];
    end
  end

endmodule

// File: hdl/pext_result_stage.sv
/*
 * Output side. Forms wrap, saturated and halved words, picks one by
 * result kind and registers it. ov_o is a one-cycle flag beside valid_o.
 */
`include "pext_params.svh"

module pext_result_stage (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  pext_op_pkg::pext_ctrl_t  ctrl_i,
  input  logic                     valid_i,
  input  pext_data_pkg::lane_sum_t sum_i,
  input  pext_data_pkg::xlen_t     cmp_word_i,
  input  pext_data_pkg::xlen_t     minmax_word_i,
  output logic                     valid_o,
  output pext_data_pkg::xlen_t     result_o,
  output logic                     ov_o
);

  import pext_op_pkg::*;
  import pext_data_pkg::*;

  localparam int NB = `PEXT_NUM_BYTES;
  localparam int BW = `PEXT_BYTE_W;

  logic [NB-1:0] top;
  logic [NB-1:0] top_bit;
  logic [NB-1:0] byte_sign;
  logic [NB-1:0] sat_top;
  logic [NB-1:0] sat_lane;
  logic [NB-1:0] neg_lane;
  xlen_t         wrap_word;
  xlen_t         half_word;
  xlen_t         sat_word;
  xlen_t         sat_min;
  xlen_t         sat_max;
  xlen_t         result_d;
  logic          ov_d;

  assign top = lane_top_mask(ctrl_i.width);

  //////////////////////////////////////////////////////////////////////
  // Wrap and halving
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < NB; k++) begin
      wrap_word[BW*k +: BW] = sum_i[k][BW-1:0];
      byte_sign[k]          = sum_i[k][BW];
      // Unsigned subtract leaves an inverted borrow in bit 8
      top_bit[k] = sum_i[k][BW] ^ (~ctrl_i.signed_op & ctrl_i.sub);
    end
    // Shift the whole word, then patch the MSB of every lane
    half_word = {top_bit[NB-1], wrap_word[`PEXT_XLEN-1:1]};
    for (int k = 0; k < NB; k++) begin
      if (top[k]) begin
        half_word[BW*k+BW-1] = top_bit[k];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Saturation
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (ctrl_i.width)
      W8: begin
        sat_min = {4{`PEXT_SAT_S8_MIN}};
        sat_max = {4{`PEXT_SAT_S8_MAX}};
      end
      W16: begin
        sat_min = {2{`PEXT_SAT_S16_MIN}};
        sat_max = {2{`PEXT_SAT_S16_MAX}};
      end
      default: begin
        sat_min = `PEXT_SAT_S32_MIN;
        sat_max = `PEXT_SAT_S32_MAX;
      end
    endcase
  end

  // Signed overflow when bits 8 and 7 disagree
  always_comb begin
    for (int k = 0; k < NB; k++) begin
      sat_top[k] = ctrl_i.signed_op ? (sum_i[k][BW] ^ sum_i[k][BW-1]) : top_bit[k];
    end
  end

  assign sat_lane = lane_spread(ctrl_i.width, sat_top);
  assign neg_lane = lane_spread(ctrl_i.width, byte_sign);

  always_comb begin
    logic [BW-1:0] clamp;
    for (int k = 0; k < NB; k++) begin
      if (ctrl_i.signed_op) begin
        clamp = neg_lane[k] ? sat_min[BW*k +: BW] : sat_max[BW*k +: BW];
      end else begin
        clamp = ctrl_i.sub ? '0 : `PEXT_SAT_U8_MAX;
      end
      sat_word[BW*k +: BW] = sat_lane[k] ? clamp : wrap_word[BW*k +: BW];
    end
  end

  assign ov_d = (ctrl_i.res_kind == RES_SAT) & (|sat_lane);

  //////////////////////////////////////////////////////////////////////
  // Result select and output registers
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (ctrl_i.res_kind)
      RES_SAT:    result_d = sat_word;
      RES_HALF:   result_d = half_word;
      RES_CMP:    result_d = cmp_word_i;
      RES_MINMAX: result_d = minmax_word_i;
      default:    result_d = wrap_word;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      ov_o    <= 1'b0;
    end else begin
      valid_o <= valid_i;
      ov_o    <= valid_i & ov_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= result_d;
    end
  end

  // Overflow comes only with a result in which some lane was clamped
  assert property (@(posedge clk_i) disable iff (rst_i)
    ov_o |-> valid_o && (result_o != $past(wrap_word)))
    else $error("ov_o raised without a clamped result");

endmodule

// File: hdl/pext_alu_top.sv
/*
 * Packed-SIMD add/sub/compare unit, two register stages deep.
 * One result per accepted request, in order, with no back-pressure.
 */
module pext_alu_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     valid_i,
  input  pext_op_pkg::pext_op_e    op_i,
  input  pext_op_pkg::lane_width_e width_i,
  input  pext_data_pkg::xlen_t     operand_a_i,
  input  pext_data_pkg::xlen_t     operand_b_i,
  output logic                     valid_o,
  output pext_data_pkg::xlen_t     result_o,
  output logic                     ov_o
);

  import pext_op_pkg::*;
  import pext_data_pkg::*;

  pext_operands_t operands;
  pext_operands_t opnd_q;
  pext_ctrl_t     ctrl_q;
  logic           valid_q;
  lane_sum_t      sum;
  xlen_t          cmp_word;
  xlen_t          minmax_word;

  assign operands = '{a: operand_a_i, b: operand_b_i};

  // Stage 1
  pext_decode u_decode (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .width_i    (width_i),
    .operands_i (operands),
    .ctrl_o     (ctrl_q),
    .operands_o (opnd_q),
    .valid_o    (valid_q)
  );

  // Stage 2 combinational datapath
  pext_lane_adder u_lane_adder (
    .ctrl_i     (ctrl_q),
    .operands_i (opnd_q),
    .sum_o      (sum)
  );

  pext_compare u_compare (
    .ctrl_i        (ctrl_q),
    .operands_i    (opnd_q),
    .sum_i         (sum),
    .cmp_word_o    (cmp_word),
    .minmax_word_o (minmax_word)
  );

  pext_result_stage u_result_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ctrl_i        (ctrl_q),
    .valid_i       (valid_q),
    .sum_i         (sum),
    .cmp_word_i    (cmp_word),
    .minmax_word_i (minmax_word),
    .valid_o       (valid_o),
    .result_o      (result_o),
    .ov_o          (ov_o)
  );

endmodule

// File: sim/pext_ref_model.svh
/*
 * Lane-by-lane reference model in 64-bit arithmetic.
 * Included inside the testbench module after the package imports.
 */
`ifndef PEXT_REF_MODEL_SVH
`define PEXT_REF_MODEL_SVH

`include "pext_params.svh"

// Expected response for one operation
typedef struct packed {
  xlen_t result;
  logic  ov;
} expect_t;

// Operations that read lanes as two's complement
function automatic logic model_signed(pext_op_e op);
  case (op)
    OP_KADD, OP_KSUB, OP_RADD, OP_RSUB, OP_SCMPLT, OP_SMIN, OP_SMAX: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

function automatic logic model_sub(pext_op_e op);
  case (op)
    OP_SUB, OP_KSUB, OP_UKSUB, OP_RSUB, OP_URSUB: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

function automatic expect_t model_op(pext_op_e op, lane_width_e width, xlen_t a, xlen_t b);
  expect_t res;
  int      w;
  longint  mask, half, x, y, exact, lo, hi, r;
  res = '0;
  case (width)
    W8:      w = 8;
    W16:     w = 16;
    default: w = 32;
  endcase
  mask = (longint'(1) << w) - 1;
  half = longint'(1) << (w - 1);
  for (int i = 0; i < `PEXT_XLEN / w; i++) begin
    x = longint'(a >> (i * w)) & mask;
    y = longint'(b >> (i * w)) & mask;
    lo = 0;
    hi = mask;
    if (model_signed(op)) begin
      x  = (x >= half) ? x - 2 * half : x;
      y  = (y >= half) ? y - 2 * half : y;
      lo = -half;
      hi = half - 1;
    end
    // Exact result before any clamp, halving or truncation
    exact = model_sub(op) ? x - y : x + y;
    case (op)
      OP_KADD, OP_UKADD, OP_KSUB, OP_UKSUB: begin
        r = (exact > hi) ? hi : (exact < lo) ? lo : exact;
        res.ov = res.ov | (r != exact);
      end
      OP_RADD, OP_URADD, OP_RSUB, OP_URSUB: r = exact >>> 1;
      OP_CMPEQ:             r = (x == y) ? mask : 0;
      OP_SCMPLT, OP_UCMPLT: r = (x < y) ? mask : 0;
      OP_SMIN, OP_UMIN:     r = (x < y) ? x : y;
      OP_SMAX, OP_UMAX:     r = (x > y) ? x : y;
      default:              r = exact;
    endcase
    res.result = res.result | xlen_t'((r & mask) << (i * w));
  end
  return res;
endfunction

`endif

// File: sim/pext_alu_tb.sv
/*
 * Random testbench for the packed-SIMD unit, fixed seed.
 * Six tests of 200 operations; results are matched in order against a model.
 */
`include "pext_params.svh"

module pext_alu_tb;

  import pext_op_pkg::*;
  import pext_data_pkg::*;

  `include "pext_ref_model.svh"

  localparam int OPS_PER_TEST   = 200;
  localparam int TIMEOUT_CYCLES = 10 + 6 * OPS_PER_TEST * 2 + 50;

  typedef struct packed {
    expect_t     exp;
    logic [31:0] due;
  } pending_t;

  logic        clk_i;
  logic        rst_i;
  logic        valid_i;
  pext_op_e    op_i;
  lane_width_e width_i;
  xlen_t       operand_a_i;
  xlen_t       operand_b_i;
  logic        valid_o;
  xlen_t       result_o;
  logic        ov_o;

  int       seed = 24;
  int       cycle = 0;
  int       check_count = 0;
  int       error_count = 0;
  pending_t pending[$];
  pending_t head;

  pext_alu_top dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .width_i     (width_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .ov_o        (ov_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Cycle count and run limit
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_word(string name, xlen_t exp, xlen_t act);
    check_count++;
    if (act !== exp) begin
      $display("** Error: %s expected 0x%08h, got 0x%08h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    check_count++;
    if (act !== exp) begin
      $display("** Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
      error_count++;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (ov_o && !valid_o) begin
        $display("ov_o was high while valid_o was low");
        error_count++;
      end
      if (valid_o) begin
        if (pending.size() == 0) begin
          $display("valid_o was high with no operation outstanding");
          error_count++;
        end else begin
          head = pending.pop_front();
          if (cycle != int'(head.due)) begin
            $display("Result came in cycle %0d, expected in cycle %0d", cycle, head.due);
            error_count++;
          end
          check_word("result_o", head.exp.result, result_o);
          check_flag("ov_o", head.exp.ov, ov_o);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  function automatic pext_op_e pick_op(int num);
    int unsigned r;
    r = $unsigned($random(seed));
    case (num)
      1:       return pext_op_e'(int'(OP_ADD) + r % 2);
      2:       return pext_op_e'(int'(OP_KADD) + r % 4);
      3:       return pext_op_e'(int'(OP_RADD) + r % 4);
      4:       return pext_op_e'(int'(OP_CMPEQ) + r % 3);
      5:       return pext_op_e'(int'(OP_SMIN) + r % 4);
      default: return pext_op_e'(r % 17);
    endcase
  endfunction

  // Bytes near the signed and unsigned extremes
  function automatic xlen_t biased_word();
    xlen_t w;
    for (int k = 0; k < `PEXT_NUM_BYTES; k++) begin
      case ($unsigned($random(seed)) % 6)
        0:       w[8*k +: 8] = 8'h00;
        1:       w[8*k +: 8] = 8'h7f;
        2:       w[8*k +: 8] = 8'h80;
        3:       w[8*k +: 8] = 8'hff;
        default: w[8*k +: 8] = $random(seed);
      endcase
    end
    return w;
  endfunction

  function automatic pext_operands_t make_operands(int num);
    pext_operands_t p;
    int unsigned    mode;
    mode = $unsigned($random(seed)) % 4;
    if (num == 1 || num == 3 || (num == 6 && mode < 2)) begin
      p.a = $random(seed);
      p.b = $random(seed);
    end else begin
      p.a = biased_word();
      p.b = biased_word();
    end
    // Equal lanes, or lanes whose top bits differ
    if (num >= 4 && mode == 2) begin
      p.b = p.a;
    end else if (num >= 4 && mode == 3) begin
      p.b = p.a ^ 32'h8080_8080;
    end
    return p;
  endfunction

  task automatic issue(pext_op_e op, lane_width_e width, pext_operands_t p);
    pending_t item;
    @(posedge clk_i);
    #1;
    valid_i     = 1'b1;
    op_i        = op;
    width_i     = width;
    operand_a_i = p.a;
    operand_b_i = p.b;
    item.exp    = model_op(op, width, p.a, p.b);
    // Result shows two edges after this drive
    item.due    = cycle + 2;
    pending.push_back(item);
  endtask

  task automatic idle();
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
  endtask

  task automatic run_test(int num, string name, logic gaps);
    int             errs_start;
    int             checks_start;
    int             waited;
    pext_op_e       op;
    lane_width_e    width;
    pext_operands_t p;
    errs_start   = error_count;
    checks_start = check_count;
    for (int n = 0; n < OPS_PER_TEST; n++) begin
      op    = pick_op(num);
      width = lane_width_e'($unsigned($random(seed)) % 3);
      p     = make_operands(num);
      issue(op, width, p);
      if (gaps && ($random(seed) & 1)) begin
        idle();
      end
    end
    idle();
    // Last result is due within the two-stage latency
    waited = 0;
    while (pending.size() != 0 && waited < 4) begin
      @(posedge clk_i);
      waited++;
    end
    $display("test %0d (%s): %0d checks, %0d errors", num, name,
             check_count - checks_start, error_count - errs_start);
  endtask

  initial begin
    rst_i       = 1'b1;
    valid_i     = 1'b0;
    op_i        = OP_ADD;
    width_i     = W8;
    operand_a_i = '0;
    operand_b_i = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // Quiet cycles so a spurious valid_o after reset is caught
    repeat (3) idle();

    run_test(1, "wrapping add/sub", 1'b0);
    run_test(2, "saturating add/sub", 1'b0);
    run_test(3, "halving add/sub", 1'b0);
    run_test(4, "lane compares", 1'b0);
    run_test(5, "lane min/max", 1'b0);
    run_test(6, "mixed ops with gaps", 1'b1);

    if (pending.size() != 0) begin
      $display("%0d operations never produced a result", pending.size());
      error_count++;
    end
    $display("All tests done: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+hdl
+incdir+sim
hdl/pext_op_pkg.sv
hdl/pext_data_pkg.sv
hdl/pext_decode.sv
hdl/pext_lane_adder.sv
hdl/pext_compare.sv
hdl/pext_result_stage.sv
hdl/pext_alu_top.sv
sim/pext_alu_tb.sv
